// File: src/split_cache_pkg.sv
`default_nettype none

package split_cache_pkg;

    // address split is tag | index | offset
    localparam int WORD_W      = 16;
    localparam int TAG_W       = 11;
    localparam int INDEX_W     = 3;
    localparam int OFFSET_W    = 2;
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;

    localparam int LINE_WORDS  = 4;                  // words per line
    localparam int LINE_COUNT  = 8;                  // lines per cache
    localparam int LINE_W      = LINE_WORDS * WORD_W;
    localparam int MEM_LINES   = 2 ** LINE_ADDR_W;   // 16K lines, 64K words

    localparam int MEM_LATENCY = 4;                  // cycles from accept to done

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [WORD_W-1:0]      addr_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [OFFSET_W-1:0]    offset_t;
    typedef logic [LINE_W-1:0]      line_t;          // word 0 sits in the top bits
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    typedef logic [$clog2(MEM_LATENCY)-1:0] lat_count_t;

    // the word at address a powers up holding a ^ MEM_INIT_XOR
    localparam word_t MEM_INIT_XOR = 16'h3C5A;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,  // dirty victim going out
        REFILL,
        FINISH      // serve the held request as a hit
    } dc_state_t;

endpackage

`default_nettype wire

// File: src/icache.sv
`default_nettype none

module icache (
    input  logic                        Clk,
    input  logic                        i_rst_n,
    input  logic                        i_fetch_req,
    input  split_cache_pkg::addr_t      i_fetch_addr,
    output logic                        o_fetch_done,
    output split_cache_pkg::word_t      o_fetch_data,
    output logic                        o_mem_rd,
    output split_cache_pkg::line_addr_t o_mem_line_addr,
    input  logic                        i_mem_done,
    input  split_cache_pkg::line_t      i_mem_line
);

    import split_cache_pkg::*;

    tag_t                  tag_q  [LINE_COUNT];
    line_t                 data_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;

    tag_t    fetch_tag;
    index_t  fetch_index;
    offset_t fetch_offset;
    int      word_lsb;
    logic    hit;
    logic    answer;
    logic    miss_start;
    logic    refill_done;

    assign fetch_tag    = i_fetch_addr[WORD_W-1 -: TAG_W];
    assign fetch_index  = i_fetch_addr[OFFSET_W +: INDEX_W];
    assign fetch_offset = i_fetch_addr[OFFSET_W-1:0];
    assign word_lsb     = (LINE_WORDS - 1 - int'(fetch_offset)) * WORD_W; // word 0 leftmost

    assign hit = valid_q[fetch_index] && (tag_q[fetch_index] == fetch_tag);

    // a done already out means the request drops in this cycle
    assign answer      = i_fetch_req && hit && !o_fetch_done;
    assign miss_start  = i_fetch_req && !hit && !o_mem_rd && !o_fetch_done;
    assign refill_done = o_mem_rd && i_mem_done;

    assign o_mem_line_addr = i_fetch_addr[WORD_W-1:OFFSET_W]; // address held until done

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            o_fetch_done <= 1'b0;
            o_mem_rd     <= 1'b0;
            valid_q      <= '0;
        end else begin
            o_fetch_done <= answer;
            if (refill_done) begin
                o_mem_rd             <= 1'b0;
                valid_q[fetch_index] <= 1'b1; // hit on the next edge
            end else if (miss_start) begin
                o_mem_rd <= 1'b1;
            end
        end
    end

    // line store and output word
    always_ff @(posedge Clk) begin
        if (refill_done) begin
            tag_q[fetch_index]  <= fetch_tag;
            data_q[fetch_index] <= i_mem_line;
        end
        if (answer) begin
            o_fetch_data <= data_q[fetch_index][word_lsb +: WORD_W];
        end
    end

    // the request level stays up until its done
    assert property (@(posedge Clk) disable iff (!i_rst_n)
        i_fetch_req && !o_fetch_done |=> i_fetch_req || o_fetch_done)
        else $error("icache: fetch request dropped before its done");

endmodule

`default_nettype wire

// File: src/dcache.sv
`default_nettype none

module dcache (
    input  logic                        Clk,
    input  logic                        i_rst_n,
    input  logic                        i_data_rd,
    input  logic                        i_data_wr,
    input  split_cache_pkg::addr_t      i_data_addr,
    input  split_cache_pkg::word_t      i_data_wdata,
    output logic                        o_data_done,
    output split_cache_pkg::word_t      o_data_rdata,
    output logic                        o_mem_rd,
    output logic                        o_mem_wr,
    output split_cache_pkg::line_addr_t o_mem_line_addr,
    output split_cache_pkg::line_t      o_mem_wline,
    input  logic                        i_mem_done,
    input  split_cache_pkg::line_t      i_mem_line
);

    import split_cache_pkg::*;

    tag_t                  tag_q  [LINE_COUNT];
    line_t                 data_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    dc_state_t             state_q;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    int      word_lsb;
    logic    req_any;
    logic    hit;
    logic    victim_dirty;
    logic    miss_start;
    logic    serve;
    logic    refill_done;

    assign req_tag    = i_data_addr[WORD_W-1 -: TAG_W];
    assign req_index  = i_data_addr[OFFSET_W +: INDEX_W];
    assign req_offset = i_data_addr[OFFSET_W-1:0];
    assign word_lsb   = (LINE_WORDS - 1 - int'(req_offset)) * WORD_W;

    assign req_any      = i_data_rd || i_data_wr;
    assign hit          = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign victim_dirty = valid_q[req_index] && dirty_q[req_index];

    // done still high means the cpu drops the request now
    assign miss_start  = (state_q == IDLE) && req_any && !hit && !o_data_done;
    assign serve       = ((state_q == IDLE) && req_any && hit && !o_data_done)
                       || (state_q == FINISH);
    assign refill_done = (state_q == REFILL) && i_mem_done;

    // victim goes back under its own tag, refill uses the request address
    assign o_mem_line_addr = (state_q == WRITEBACK) ? {tag_q[req_index], req_index}
                                                    : i_data_addr[WORD_W-1:OFFSET_W];
    assign o_mem_wline     = data_q[req_index];

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            state_q     <= IDLE;
            o_mem_rd    <= 1'b0;
            o_mem_wr    <= 1'b0;
            o_data_done <= 1'b0;
            valid_q     <= '0;
            dirty_q     <= '0;
        end else begin
            o_data_done <= serve;
            case (state_q)
                IDLE: begin
                    if (miss_start) begin
                        if (victim_dirty) begin
                            state_q  <= WRITEBACK;
                            o_mem_wr <= 1'b1;
                        end else begin
                            state_q  <= REFILL;
                            o_mem_rd <= 1'b1;
                        end
                    end
                end
                WRITEBACK: begin
                    if (i_mem_done) begin
                        state_q            <= REFILL;
                        o_mem_wr           <= 1'b0;
                        o_mem_rd           <= 1'b1;
                        dirty_q[req_index] <= 1'b0; // memory now holds the victim
                    end
                end
                REFILL: begin
                    if (i_mem_done) begin
                        state_q            <= FINISH;
                        o_mem_rd           <= 1'b0;
                        valid_q[req_index] <= 1'b1;
                        dirty_q[req_index] <= 1'b0;
                    end
                end
                FINISH: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
            if (serve && i_data_wr) begin
                dirty_q[req_index] <= 1'b1;
            end
        end
    end

    // line store, write hits and read data
    always_ff @(posedge Clk) begin
        if (refill_done) begin
            tag_q[req_index]  <= req_tag;
            data_q[req_index] <= i_mem_line;
        end else if (serve && i_data_wr) begin
            data_q[req_index][word_lsb +: WORD_W] <= i_data_wdata;
        end
        if (serve && i_data_rd) begin
            o_data_rdata <= data_q[req_index][word_lsb +: WORD_W];
        end
    end

    // memory sees one kind of transfer at a time
    assert property (@(posedge Clk) disable iff (!i_rst_n)
        !(o_mem_rd && o_mem_wr))
        else $error("dcache: memory read and write requested together");

    assert property (@(posedge Clk) disable iff (!i_rst_n)
        !(i_data_rd && i_data_wr))
        else $error("dcache: cpu read and write raised together");

endmodule

`default_nettype wire

// File: src/main_memory.sv
`default_nettype none

module main_memory (
    input  logic                        Clk,
    input  logic                        i_rst_n,
    input  logic                        i_i_rd,
    input  split_cache_pkg::line_addr_t i_i_line_addr,
    output logic                        o_i_done,
    output split_cache_pkg::line_t      o_i_line,
    input  logic                        i_d_rd,
    input  logic                        i_d_wr,
    input  split_cache_pkg::line_addr_t i_d_line_addr,
    input  split_cache_pkg::line_t      i_d_wline,
    output logic                        o_d_done,
    output split_cache_pkg::line_t      o_d_line
);

    import split_cache_pkg::*;

    line_t      mem [MEM_LINES];
    logic       busy_q;
    logic       grant_d_q;  // data port owns the transfer
    lat_count_t count_q;
    logic       wr_q;
    line_addr_t addr_q;
    line_t      wline_q;
    line_t      line_q;

    logic d_req;
    logic free;
    logic accept;
    logic finish;

    assign d_req  = i_d_rd || i_d_wr;
    // the finished port still holds its request during its done cycle
    assign free   = !busy_q && !o_i_done && !o_d_done;
    assign accept = free && (d_req || i_i_rd);
    assign finish = busy_q && (count_q == '0);

    assign o_i_line = line_q;
    assign o_d_line = line_q;

    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem[l][(LINE_WORDS - 1 - w) * WORD_W +: WORD_W] =
                    addr_t'(l * LINE_WORDS + w) ^ MEM_INIT_XOR;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!i_rst_n) begin
            busy_q    <= 1'b0;
            grant_d_q <= 1'b0;
            count_q   <= '0;
            o_i_done  <= 1'b0;
            o_d_done  <= 1'b0;
        end else begin
            o_i_done <= 1'b0;
            o_d_done <= 1'b0;
            if (accept) begin
                busy_q    <= 1'b1;
                grant_d_q <= d_req; // data port wins a tie
                count_q   <= lat_count_t'(MEM_LATENCY - 1);
            end else if (finish) begin
                busy_q   <= 1'b0;
                o_d_done <= grant_d_q;
                o_i_done <= !grant_d_q;
            end else if (busy_q) begin
                count_q <= count_q - lat_count_t'(1);
            end
        end
    end

    always @(posedge Clk) begin
        if (accept) begin
            addr_q  <= d_req ? i_d_line_addr : i_i_line_addr;
            wr_q    <= i_d_wr;
            wline_q <= i_d_wline;
        end
        if (finish) begin
            if (wr_q) begin
                mem[addr_q] <= wline_q; // write lands in the done cycle
            end
            line_q <= mem[addr_q];
        end
    end

    // each done belongs to the port accepted MEM_LATENCY cycles before it
    assert property (@(posedge Clk) disable iff (!i_rst_n)
        $rose(o_d_done) |-> $past(accept && d_req, MEM_LATENCY + 1))
        else $error("main_memory: data done not at its latency after the accept");

    assert property (@(posedge Clk) disable iff (!i_rst_n)
        $rose(o_i_done) |-> $past(accept && !d_req, MEM_LATENCY + 1))
        else $error("main_memory: instruction done not at its latency after the accept");

endmodule

`default_nettype wire

// File: src/split_cache_top.sv
`default_nettype none

module split_cache_top (
    input  logic                   Clk,
    input  logic                   i_rst_n,
    input  logic                   i_fetch_req,
    input  split_cache_pkg::addr_t i_fetch_addr,
    output logic                   o_fetch_done,
    output split_cache_pkg::word_t o_fetch_data,
    input  logic                   i_data_rd,
    input  logic                   i_data_wr,
    input  split_cache_pkg::addr_t i_data_addr,
    input  split_cache_pkg::word_t i_data_wdata,
    output logic                   o_data_done,
    output split_cache_pkg::word_t o_data_rdata
);

    import split_cache_pkg::*;

    // instruction cache to memory
    logic       ic_mem_rd;
    line_addr_t ic_mem_line_addr;
    logic       ic_mem_done;
    line_t      ic_mem_line;

    // data cache to memory
    logic       dc_mem_rd;
    logic       dc_mem_wr;
    line_addr_t dc_mem_line_addr;
    line_t      dc_mem_wline;
    logic       dc_mem_done;
    line_t      dc_mem_line;

    icache icache_inst (
        .Clk             (Clk),
        .i_rst_n         (i_rst_n),
        .i_fetch_req     (i_fetch_req),
        .i_fetch_addr    (i_fetch_addr),
        .o_fetch_done    (o_fetch_done),
        .o_fetch_data    (o_fetch_data),
        .o_mem_rd        (ic_mem_rd),
        .o_mem_line_addr (ic_mem_line_addr),
        .i_mem_done      (ic_mem_done),
        .i_mem_line      (ic_mem_line)
    );

    dcache dcache_inst (
        .Clk             (Clk),
        .i_rst_n         (i_rst_n),
        .i_data_rd       (i_data_rd),
        .i_data_wr       (i_data_wr),
        .i_data_addr     (i_data_addr),
        .i_data_wdata    (i_data_wdata),
        .o_data_done     (o_data_done),
        .o_data_rdata    (o_data_rdata),
        .o_mem_rd        (dc_mem_rd),
        .o_mem_wr        (dc_mem_wr),
        .o_mem_line_addr (dc_mem_line_addr),
        .o_mem_wline     (dc_mem_wline),
        .i_mem_done      (dc_mem_done),
        .i_mem_line      (dc_mem_line)
    );

    main_memory main_memory_inst (
        .Clk           (Clk),
        .i_rst_n       (i_rst_n),
        .i_i_rd        (ic_mem_rd),
        .i_i_line_addr (ic_mem_line_addr),
        .o_i_done      (ic_mem_done),
        .o_i_line      (ic_mem_line),
        .i_d_rd        (dc_mem_rd),
        .i_d_wr        (dc_mem_wr),
        .i_d_line_addr (dc_mem_line_addr),
        .i_d_wline     (dc_mem_wline),
        .o_d_done      (dc_mem_done),
        .o_d_line      (dc_mem_line)
    );

endmodule

`default_nettype wire

// File: verification/split_cache_tb.sv
`default_nettype none

module split_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import split_cache_pkg::*;

    localparam int CLK_HALF     = 5;
    localparam int RESET_CYCLES = 10;
    localparam int OP_CYCLES    = 40;   // watchdog budget per operation
    localparam int SLACK_CYCLES = 100;
    localparam int MAX_CYCLES   = 40;   // longest accepted miss latency

    logic  Clk;
    logic  i_rst_n;
    logic  i_fetch_req;
    addr_t i_fetch_addr;
    logic  o_fetch_done;
    word_t o_fetch_data;
    logic  i_data_rd;
    logic  i_data_wr;
    addr_t i_data_addr;
    word_t i_data_wdata;
    logic  o_data_done;
    word_t o_data_rdata;

    int    op_kind   [$];
    addr_t op_addr   [$];
    word_t op_wdata  [$];
    word_t op_expect [$];
    logic  loaded;
    logic  finished;

    // expected tags, valid and dirty bits of both caches
    tag_t                  ic_tag [LINE_COUNT];
    logic [LINE_COUNT-1:0] ic_valid;
    tag_t                  dc_tag [LINE_COUNT];
    logic [LINE_COUNT-1:0] dc_valid;
    logic [LINE_COUNT-1:0] dc_dirty;

    split_cache_top split_cache_top_inst (
        .Clk          (Clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .o_fetch_done (o_fetch_done),
        .o_fetch_data (o_fetch_data),
        .i_data_rd    (i_data_rd),
        .i_data_wr    (i_data_wr),
        .i_data_addr  (i_data_addr),
        .i_data_wdata (i_data_wdata),
        .o_data_done  (o_data_done),
        .o_data_rdata (o_data_rdata)
    );

    initial Clk = 1'b0;
    always #CLK_HALF Clk = ~Clk;

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h",
                                     $time, what, actual, expected));
    endtask

    task automatic check_cycles(input int actual, input int lo, input int hi,
                                input string what);
        if (actual < lo || actual > hi)
            report_failure($sformatf("Fail at %0t: %s is %0d cycles, expected %0d to %0d",
                                     $time, what, actual, lo, hi));
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("%s, at time %0t", what, $time));
    endtask

    task automatic load_testdata();
        int    fd;
        int    n;
        int    kind;
        addr_t a;
        word_t w;
        word_t e;
        string text;
        fd = $fopen("verification/split_cache_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("the test data file verification/split_cache_testdata.txt is missing");
        end else begin
            while ($fgets(text, fd) > 0) begin
                n = $sscanf(text, "%h %h %h %h", kind, a, w, e); // comment lines give 0
                if (n == 4) begin
                    op_kind.push_back(kind);
                    op_addr.push_back(a);
                    op_wdata.push_back(w);
                    op_expect.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int fetch_latency(input addr_t a);
        if (ic_valid[a[4:2]] && ic_tag[a[4:2]] == a[15:5])
            return 1;
        return MEM_LATENCY + 2;
    endfunction

    function automatic int data_latency(input addr_t a);
        if (dc_valid[a[4:2]] && dc_tag[a[4:2]] == a[15:5])
            return 1;
        if (dc_valid[a[4:2]] && dc_dirty[a[4:2]])
            return 2 * MEM_LATENCY + 2;  // victim goes out first
        return MEM_LATENCY + 2;
    endfunction

    function automatic void track_caches(input int kind, input addr_t f_addr,
                                         input addr_t d_addr);
        if (kind == 0 || kind == 3) begin
            ic_valid[f_addr[4:2]] = 1'b1;
            ic_tag[f_addr[4:2]]   = f_addr[15:5];
        end
        if (kind != 0) begin
            if (!dc_valid[d_addr[4:2]] || dc_tag[d_addr[4:2]] != d_addr[15:5])
                dc_dirty[d_addr[4:2]] = 1'b0;  // refilled line is clean
            dc_valid[d_addr[4:2]] = 1'b1;
            dc_tag[d_addr[4:2]]   = d_addr[15:5];
            if (kind == 2)
                dc_dirty[d_addr[4:2]] = 1'b1;
        end
    endfunction

    task automatic run_operation(input int kind, input addr_t a, input word_t w,
                                 input word_t e);
        addr_t d_addr;
        logic  f_wait;
        logic  d_wait;
        int    cycles;
        int    f_cycles;
        int    d_cycles;
        int    f_min;
        int    d_min;
        d_addr       = (kind == 3) ? w : a;  // kind 3 keeps the data address in wdata
        f_wait       = (kind == 0) || (kind == 3);
        d_wait       = (kind != 0);
        f_min        = fetch_latency(a);
        d_min        = data_latency(d_addr);
        cycles       = 0;
        f_cycles     = 0;
        d_cycles     = 0;
        i_fetch_req  = f_wait;
        i_fetch_addr = a;
        i_data_rd    = (kind == 1) || (kind == 3);
        i_data_wr    = (kind == 2);
        i_data_addr  = d_addr;
        i_data_wdata = (kind == 2) ? w : '0;
        while (f_wait || d_wait) begin
            @(posedge Clk);
            #1;
            cycles++;
            if (f_wait && o_fetch_done) begin
                f_wait      = 1'b0;
                f_cycles    = cycles;
                i_fetch_req = 1'b0;
                check_word(o_fetch_data, e, $sformatf("fetch data at %h", a));
            end
            if (d_wait && o_data_done) begin
                d_wait    = 1'b0;
                d_cycles  = cycles;
                i_data_rd = 1'b0;
                i_data_wr = 1'b0;
                if (kind != 2)
                    check_word(o_data_rdata, e, $sformatf("read data at %h", d_addr));
            end
        end
        if (kind == 0 || kind == 3)
            check_cycles(f_cycles, f_min, (f_min == 1) ? 1 : MAX_CYCLES, "fetch latency");
        if (kind != 0)
            check_cycles(d_cycles, d_min, (d_min == 1) ? 1 : MAX_CYCLES, "data latency");
        if (kind == 3)
            check_cycles(d_cycles, 1, f_cycles, "data done against fetch done"); // data wins
        track_caches(kind, a, d_addr);
        @(posedge Clk);  // idle cycle so the done pulse falls before the next request
        #1;
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_data_rd    = 1'b0;
        i_data_wr    = 1'b0;
        i_data_addr  = '0;
        i_data_wdata = '0;
        loaded       = 1'b0;
        finished     = 1'b0;
        ic_valid     = '0;
        dc_valid     = '0;
        dc_dirty     = '0;
        load_testdata();
        loaded = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge Clk);
            #1;
            check_done(o_fetch_done, 1'b0, "fetch done was high during reset");
            check_done(o_data_done, 1'b0, "data done was high during reset");
        end
        i_rst_n = 1'b1;
        @(posedge Clk);
        #1;
        check_done(o_fetch_done, 1'b0, "fetch done was high in the cycle after reset");
        check_done(o_data_done, 1'b0, "data done was high in the cycle after reset");
        for (int i = 0; i < op_kind.size(); i++)
            run_operation(op_kind[i], op_addr[i], op_wdata[i], op_expect[i]);
        finished = 1'b1;
        $display("Test passed");
        $finish;
    end

    // watchdog sized from the number of operations in the data file
    initial begin
        wait (loaded);
        repeat (op_kind.size() * OP_CYCLES + SLACK_CYCLES) @(posedge Clk);
        check_done(finished, 1'b1, "an operation never finished before the watchdog ran out");
    end

endmodule

`default_nettype wire

// File: verification/split_cache_testdata.txt
# columns, all hex: kind address wdata expected
# kind 0 fetch, 1 read, 2 write, 3 fetch at address with a read at wdata
# fetch miss, then hits in the same line
0 0100 0000 3D5A
0 0102 0000 3D58
0 0103 0000 3D59
0 1234 0000 2E6E
0 7FFF 0000 43A5
0 7FFC 0000 43A6
# data reads, write hit, read back
1 8000 0000 BC5A
1 8001 0000 BC5B
2 8002 1111 0000
1 8002 0000 1111
# same index, other tag, forces the write-back of 8000 line
1 9000 0000 AC5A
1 8002 0000 1111
1 8000 0000 BC5A
# write miss into an empty line
2 8014 BEEF 0000
1 8014 0000 BEEF
1 8015 0000 BC4F
# write miss over a dirty victim
2 A014 2222 0000
1 8014 0000 BEEF
1 A014 0000 2222
# fetch miss and data miss in the same cycle
2 C008 3E5A 0000
1 E008 0000 DC52
3 0200 C008 3E5A
# fetch miss alongside a data hit on a dirty line
2 C00C 3F5E 0000
3 0304 C00C 3F5E
0 0101 0000 3D5B

// File: split_cache.f
src/split_cache_pkg.sv
src/icache.sv
src/dcache.sv
src/main_memory.sv
src/split_cache_top.sv
verification/split_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench, the exit status gives pass or fail
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f split_cache.f \
        --top-module split_cache_tb -o split_cache_sim &&
    ./obj_dir/split_cache_sim ||
    { echo "split_cache simulation did not pass"; exit 1; }
